// ==== src/exm_pkg.sv ====
// widths, op and exception codes, address union, pipeline stage structs
`default_nettype none

package exm_pkg;

    localparam int DATA_W     = 32;
    localparam int MEM_WORDS  = 64;
    localparam int MEM_IDX_W  = $clog2(MEM_WORDS);
    localparam int MUL_CYCLES = 32;
    localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);

    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_AND = 4'd3,
        OP_OR  = 4'd4,
        OP_SLT = 4'd5,
        OP_MUL = 4'd6,
        OP_LW  = 4'd7,
        OP_LBU = 4'd8,
        OP_SW  = 4'd9,
        OP_SB  = 4'd10
    } op_e;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_ADEL = 2'd1, // load address error
        EXC_ADES = 2'd2  // store address error
    } exc_e;

    typedef struct packed {
        logic [DATA_W-MEM_IDX_W-3:0] tag;
        logic [MEM_IDX_W-1:0]        index;  // ram word
        logic [1:0]                  offset; // byte lane
    } mem_addr_t;

    // same word seen as data or as a ram address
    typedef union packed {
        logic [DATA_W-1:0] word;
        mem_addr_t         addr;
    } addr_word_u;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        op_e               op;
        logic [DATA_W-1:0] rs_val;
        logic [DATA_W-1:0] rt_val;
        logic [15:0]       imm;
        logic [4:0]        wraddr;
    } issue_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] pc;
        op_e               op;
        addr_word_u        result; // alu value or agen address
        logic [DATA_W-1:0] sdata;  // store data
        logic [4:0]        wraddr;
        exc_e              exc;
    } ex_out_t;

    typedef struct packed {
        logic [4:0]        wraddr;
        logic [DATA_W-1:0] data;
    } wb_t;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        exc_e              code;
    } exc_t;

endpackage

`default_nettype wire

// ==== src/mul_counter.sv ====
// multiply iteration down-counter with last-cycle flag
`default_nettype none
`timescale 1ns/1ns

module mul_counter (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic cancel,
    output logic last
);
    import exm_pkg::*;

    logic [MUL_CNT_W-1:0] count;
    logic                 running;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count   <= '0;
            running <= 1'b0;
        end else if (cancel) begin
            count   <= '0;
            running <= 1'b0;
        end else if (start) begin
            count   <= MUL_CNT_W'(MUL_CYCLES - 1);
            running <= 1'b1;
        end else if (running) begin
            if (count != '0) begin
                count <= count - MUL_CNT_W'(1);
            end else begin
                running <= 1'b0; // final iteration done
            end
        end
    end

    assign last = running && (count == '0);

endmodule

`default_nettype wire

// ==== src/exm_ctrl.sv ====
// issue and multiply control FSM with busy and flush handling
`default_nettype none
`timescale 1ns/1ns

module exm_ctrl (
    input  logic         clk,
    input  logic         rst,
    input  logic         issue_valid,
    input  exm_pkg::op_e issue_op,
    input  logic         flush,
    input  logic         mul_last,
    output logic         mul_start,
    output logic         mul_cancel,
    output logic         mul_load,
    output logic         mul_step,
    output logic         mul_done,
    output logic         flush_q,
    output logic         busy
);
    import exm_pkg::*;

    typedef enum logic {IDLE, MUL} state_e;

    state_e state;
    state_e state_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        mul_start  = 1'b0;
        mul_load   = 1'b0;
        mul_step   = 1'b0;
        mul_done   = 1'b0;
        mul_cancel = 1'b0;
        case (state)
            IDLE: begin
                if (issue_valid && issue_op == OP_MUL && !flush) begin
                    mul_start  = 1'b1;
                    mul_load   = 1'b1;
                    state_next = MUL;
                end
            end
            MUL: begin
                if (flush) begin
                    mul_cancel = 1'b1; // drop the product
                    state_next = IDLE;
                end else begin
                    mul_step = 1'b1;
                    if (mul_last) begin
                        mul_done   = 1'b1;
                        state_next = IDLE;
                    end
                end
            end
            default: state_next = IDLE;
        endcase
    end

    assign busy    = (state == MUL);
    assign flush_q = flush; // bubble at this same edge

    a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !issue_valid)
        else $error("issue_valid high while busy");

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        mul_start |-> !mul_last)
        else $error("mul_start while the counter is still running");

endmodule

`default_nettype wire

// ==== src/exec_unit.sv ====
// alu, shift-add multiplier, address generation and alignment check
`default_nettype none
`timescale 1ns/1ns

module exec_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_valid,
    input  exm_pkg::issue_t  issue,
    input  logic             mul_load,
    input  logic             mul_step,
    input  logic             mul_done,
    output exm_pkg::ex_out_t ex_out
);
    import exm_pkg::*;

    logic [DATA_W-1:0] mcand;
    logic [DATA_W-1:0] mplier;
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] acc_next;
    logic [DATA_W-1:0] mul_pc;
    logic [4:0]        mul_wraddr;
    addr_word_u        agen;

    assign acc_next = acc + (mplier[0] ? mcand : '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mcand  <= '0;
            mplier <= '0;
            acc    <= '0;
        end else if (mul_load) begin
            mcand  <= issue.rs_val;
            mplier <= issue.rt_val;
            acc    <= '0;
        end else if (mul_step) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            acc    <= acc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_load) begin
            mul_pc     <= issue.pc; // kept for the late result
            mul_wraddr <= issue.wraddr;
        end
    end

    assign agen.word = issue.rs_val + {{16{issue.imm[15]}}, issue.imm};

    always_comb begin
        ex_out.valid       = issue_valid && (issue.op != OP_MUL);
        ex_out.pc          = issue.pc;
        ex_out.op          = issue.op;
        ex_out.sdata       = issue.rt_val;
        ex_out.wraddr      = issue.wraddr;
        ex_out.exc         = EXC_NONE;
        ex_out.result.word = '0;
        case (issue.op)
            OP_ADD: ex_out.result.word = issue.rs_val + issue.rt_val;
            OP_SUB: ex_out.result.word = issue.rs_val - issue.rt_val;
            OP_AND: ex_out.result.word = issue.rs_val & issue.rt_val;
            OP_OR:  ex_out.result.word = issue.rs_val | issue.rt_val;
            OP_SLT: ex_out.result.word = {{(DATA_W-1){1'b0}},
                                          $signed(issue.rs_val) < $signed(issue.rt_val)};
            OP_LW, OP_LBU, OP_SW, OP_SB: ex_out.result = agen;
            default: ex_out.result.word = '0;
        endcase
        if (issue.op == OP_LW && agen.addr.offset != 2'b00) begin
            ex_out.exc = EXC_ADEL;
        end else if (issue.op == OP_SW && agen.addr.offset != 2'b00) begin
            ex_out.exc = EXC_ADES;
        end
        if (mul_done) begin
            ex_out.valid       = 1'b1;
            ex_out.pc          = mul_pc;
            ex_out.op          = OP_MUL;
            ex_out.result.word = acc_next; // includes the last step
            ex_out.sdata       = '0;
            ex_out.wraddr      = mul_wraddr;
            ex_out.exc         = EXC_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== src/reg_ex_mem.sv ====
// EX/MEM pipeline register with flush bubble
`default_nettype none
`timescale 1ns/1ns

module reg_ex_mem (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  exm_pkg::ex_out_t ex_in,
    output exm_pkg::ex_out_t mem_out
);
    import exm_pkg::*;

    // empty slot that still carries a pc
    function automatic ex_out_t bubble(input logic [DATA_W-1:0] pc);
        ex_out_t b;
        b.valid       = 1'b0;
        b.pc          = pc;
        b.op          = OP_NOP;
        b.result.word = '0;
        b.sdata       = '0;
        b.wraddr      = '0;
        b.exc         = EXC_NONE;
        return b;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_out <= bubble('0);
        end else if (flush) begin
            mem_out <= bubble(ex_in.pc); // pc survives the flush
        end else begin
            mem_out <= ex_in;
        end
    end

endmodule

`default_nettype wire

// ==== src/mem_stage.sv ====
// data ram, byte-lane stores, load extraction, wb and exception strobes
`default_nettype none
`timescale 1ns/1ns

module mem_stage (
    input  logic             clk,
    input  logic             rst,
    input  exm_pkg::ex_out_t mem_in,
    output logic             wb_valid,
    output exm_pkg::wb_t     wb,
    output logic             exc_valid,
    output exm_pkg::exc_t    exc
);
    import exm_pkg::*;

    logic [DATA_W-1:0]    ram [MEM_WORDS];
    logic [MEM_IDX_W-1:0] idx;
    logic [1:0]           off;
    logic                 ok;
    logic [3:0]           be;
    logic [DATA_W-1:0]    wdata;
    logic [DATA_W-1:0]    rd_q;
    logic [DATA_W-1:0]    pass_q;
    op_e                  op_q;
    logic [1:0]           off_q;
    logic [4:0]           wraddr_q;

    assign idx = mem_in.result.addr.index; // wraps past MEM_WORDS
    assign off = mem_in.result.addr.offset;
    assign ok  = mem_in.valid && (mem_in.exc == EXC_NONE);

    always_comb begin
        be    = 4'b0000;
        wdata = mem_in.sdata;
        if (ok && mem_in.op == OP_SW) begin
            be = 4'b1111;
        end else if (ok && mem_in.op == OP_SB) begin
            be    = 4'b0001 << off;
            wdata = {4{mem_in.sdata[7:0]}}; // byte on every lane
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                ram[idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
        rd_q     <= ram[idx];
        pass_q   <= mem_in.result.word;
        op_q     <= mem_in.op;
        off_q    <= off;
        wraddr_q <= mem_in.wraddr;
        exc.pc   <= mem_in.pc;
        exc.code <= mem_in.exc;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid  <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            wb_valid  <= ok && (mem_in.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR,
                                                  OP_SLT, OP_MUL, OP_LW, OP_LBU});
            exc_valid <= mem_in.valid && (mem_in.exc != EXC_NONE);
        end
    end

    always_comb begin
        wb.wraddr = wraddr_q;
        case (op_q)
            OP_LW:   wb.data = rd_q;
            OP_LBU:  wb.data = {{(DATA_W-8){1'b0}}, rd_q[8*off_q +: 8]};
            default: wb.data = pass_q; // alu and mul
        endcase
    end

    a_exc_misaligned: assert property (@(posedge clk) disable iff (rst)
        (mem_in.valid && mem_in.exc != EXC_NONE)
            |-> (mem_in.op inside {OP_LW, OP_SW} && off != 2'b00))
        else $error("exception on an aligned or non-word access");

endmodule

`default_nettype wire

// ==== src/exm_top.sv ====
// top level with control, multiply counter, execute, EX/MEM register and memory stage
`default_nettype none
`timescale 1ns/1ns

module exm_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_valid,
    input  exm_pkg::issue_t issue,
    input  logic            flush,
    output logic            busy,
    output logic            wb_valid,
    output exm_pkg::wb_t    wb,
    output logic            exc_valid,
    output exm_pkg::exc_t   exc
);
    import exm_pkg::*;

    logic    mul_start;
    logic    mul_cancel;
    logic    mul_last;
    logic    mul_load;
    logic    mul_step;
    logic    mul_done;
    logic    flush_q;
    ex_out_t ex_out;
    ex_out_t mem_in;

    exm_ctrl exm_ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue.op),
        .flush       (flush),
        .mul_last    (mul_last),
        .mul_start   (mul_start),
        .mul_cancel  (mul_cancel),
        .mul_load    (mul_load),
        .mul_step    (mul_step),
        .mul_done    (mul_done),
        .flush_q     (flush_q),
        .busy        (busy)
    );

    mul_counter mul_counter_inst (
        .clk    (clk),
        .rst    (rst),
        .start  (mul_start),
        .cancel (mul_cancel),
        .last   (mul_last)
    );

    exec_unit exec_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .mul_load    (mul_load),
        .mul_step    (mul_step),
        .mul_done    (mul_done),
        .ex_out      (ex_out)
    );

    reg_ex_mem reg_ex_mem_inst (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush_q),
        .ex_in   (ex_out),
        .mem_out (mem_in)
    );

    mem_stage mem_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .mem_in    (mem_in),
        .wb_valid  (wb_valid),
        .wb        (wb),
        .exc_valid (exc_valid),
        .exc       (exc)
    );

endmodule

`default_nettype wire

// ==== test/exm_tb.sv ====
// case-file and random burst testbench for exm_top
`default_nettype none
`timescale 1ns/1ns

module exm_tb;
    import exm_pkg::*;

    localparam int TIMEOUT = 100;

    logic        clk;
    logic        rst;
    logic        issue_valid;
    issue_t      issue;
    logic        flush;
    logic        busy;
    logic        wb_valid;
    wb_t         wb;
    logic        exc_valid;
    exc_t        exc;

    int          errors;
    int          tests;
    int          fd;
    int          cnt;
    string       line;
    logic [3:0]  op_v;
    logic [31:0] rs_v;
    logic [31:0] rt_v;
    logic [15:0] imm_v;
    logic [4:0]  wr_v;
    logic [3:0]  fl_v;
    logic [3:0]  kind_v;
    logic [31:0] exp_v;

    exm_top exm_top_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .flush       (flush),
        .busy        (busy),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .exc_valid   (exc_valid),
        .exc         (exc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reference result of a register-register op
    function automatic logic [31:0] alu_ref(input op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            default: return 32'd0;
        endcase
    endfunction

    task automatic drive_issue(input op_e op, input logic [31:0] a, input logic [31:0] b,
                               input logic [15:0] imm, input logic [4:0] wr,
                               input logic [31:0] pc);
        issue_valid   = 1'b1;
        issue.pc      = pc;
        issue.op      = op;
        issue.rs_val  = a;
        issue.rt_val  = b;
        issue.imm     = imm;
        issue.wraddr  = wr;
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (wb_valid || exc_valid) begin
                $display("unexpected strobe: wb_valid %b exc_valid %b", wb_valid, exc_valid);
                errors++;
            end
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("timeout: busy stayed high for %0d cycles", TIMEOUT);
            errors++;
        end
    endtask

    task automatic wait_strobe(output logic found);
        int n;
        found = 1'b0;
        n = 0;
        while (!found && n < TIMEOUT) begin
            @(negedge clk);
            found = wb_valid || exc_valid;
            n++;
        end
        if (!found) begin
            $display("timeout: no writeback or exception strobe in %0d cycles", TIMEOUT);
            errors++;
        end
    endtask

    task automatic run_case(input int num, input logic [3:0] op_raw, input logic [31:0] a,
                            input logic [31:0] b, input logic [15:0] imm,
                            input logic [4:0] wr, input logic [3:0] fl,
                            input logic [3:0] kind, input logic [31:0] expv);
        op_e         op;
        logic        found;
        logic [31:0] pc;
        int          err0;
        op   = op_e'(op_raw);
        pc   = 32'h0000_1000 + 32'(num << 2);
        err0 = errors;
        @(negedge clk);
        drive_issue(op, a, b, imm, wr, pc);
        flush = fl[0] && (op != OP_MUL); // flush on the issue cycle
        @(negedge clk);
        issue_valid = 1'b0;
        flush       = 1'b0;
        if (op == OP_MUL) begin
            if (!busy) begin
                $display("busy did not rise after the MUL issue");
                errors++;
            end
            if (fl[0]) begin
                repeat (5) @(negedge clk); // flush mid multiply
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
                if (busy) begin
                    $display("busy still high after the flush");
                    errors++;
                end
            end else begin
                wait_idle();
            end
        end
        if (kind == 4'd0) begin
            expect_quiet(op == OP_MUL ? 40 : 4);
        end else begin
            wait_strobe(found);
            if (found && kind == 4'd1) begin
                if (!wb_valid) begin
                    $display("exception strobe where a writeback was expected");
                    errors++;
                end else begin
                    if (wb.wraddr !== wr) begin
                        $display("mismatch wb.wraddr: got %h expected %h", wb.wraddr, wr);
                        errors++;
                    end
                    if (wb.data !== expv) begin
                        $display("mismatch wb.data: got %h expected %h", wb.data, expv);
                        errors++;
                    end
                end
            end else if (found) begin
                if (!exc_valid || wb_valid) begin
                    $display("writeback strobe where only an exception was expected");
                    errors++;
                end else begin
                    if (exc.pc !== pc) begin
                        $display("mismatch exc.pc: got %h expected %h", exc.pc, pc);
                        errors++;
                    end
                    if ({30'b0, exc.code} !== expv) begin
                        $display("mismatch exc.code: got %h expected %h", exc.code, expv[1:0]);
                        errors++;
                    end
                end
            end
            expect_quiet(2); // one strobe per instruction
        end
        tests++;
        $display("test %0d %0s: %0s", num, op.name(), (errors == err0) ? "ok" : "FAILED");
    endtask

    // random alu ops on consecutive cycles with in-order results
    task automatic run_burst(input int num, input int len);
        logic [31:0] exp_data[$];
        logic [4:0]  exp_wr[$];
        op_e         op;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  wr;
        int          issued;
        int          got;
        int          n;
        int          err0;
        err0   = errors;
        issued = 0;
        got    = 0;
        n      = 0;
        while ((issued < len || exp_data.size() > 0) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            if (wb_valid) begin
                if (exp_data.size() == 0) begin
                    $display("writeback strobe with nothing in flight");
                    errors++;
                end else begin
                    if (wb.wraddr !== exp_wr[0]) begin
                        $display("mismatch wb.wraddr: got %h expected %h", wb.wraddr, exp_wr[0]);
                        errors++;
                    end
                    if (wb.data !== exp_data[0]) begin
                        $display("mismatch wb.data: got %h expected %h", wb.data, exp_data[0]);
                        errors++;
                    end
                    void'(exp_data.pop_front());
                    void'(exp_wr.pop_front());
                    got++;
                end
            end else if (got > 0 && exp_data.size() > 0) begin
                $display("gap between back-to-back writeback strobes");
                errors++;
            end
            if (exc_valid) begin
                $display("exception strobe during an alu burst");
                errors++;
            end
            if (issued < len) begin
                op = op_e'(4'($urandom_range(5, 1)));
                a  = $urandom();
                b  = $urandom();
                wr = 5'($urandom());
                drive_issue(op, a, b, 16'h0000, wr, 32'h0000_2000 + 32'(issued << 2));
                exp_data.push_back(alu_ref(op, a, b));
                exp_wr.push_back(wr);
                issued++;
            end else begin
                issue_valid = 1'b0;
            end
        end
        if (issued < len || exp_data.size() > 0) begin
            $display("timeout: burst writebacks still missing after %0d cycles", TIMEOUT);
            errors++;
        end
        tests++;
        $display("test %0d burst of %0d: %0s", num, len, (errors == err0) ? "ok" : "FAILED");
    endtask

    initial begin
        errors      = 0;
        tests       = 0;
        rst         = 1'b1;
        issue_valid = 1'b0;
        flush       = 1'b0;
        issue       = '0;
        void'($urandom(32'h65a8));
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("test/exm_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open test/exm_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt  = $fgets(line, fd);
                if (cnt > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                  op_v, rs_v, rt_v, imm_v, wr_v, fl_v, kind_v, exp_v);
                    if (cnt != 8) begin
                        $display("malformed case line: %s", line);
                        errors++;
                    end else begin
                        run_case(tests + 1, op_v, rs_v, rt_v, imm_v, wr_v, fl_v, kind_v, exp_v);
                    end
                end
            end
            $fclose(fd);
        end

        for (int g = 0; g < 6; g++) begin
            run_burst(tests + 1, 4);
        end
        expect_quiet(3);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/exm_cases.txt ====
# op rs_val rt_val imm wraddr flush kind expect  (all hex)
# op 1 add 2 sub 3 and 4 or 5 slt 6 mul 7 lw 8 lbu 9 sw a sb, kind 0 none 1 wb 2 exc
1 00000005 00000007 0000 03 0 1 0000000c
2 00000005 00000007 0000 04 0 1 fffffffe
3 f0f0ff00 0ff0f0f0 0000 05 0 1 00f0f000
4 f0f0ff00 0ff0f0f0 0000 06 0 1 fff0fff0
5 ffffffff 00000001 0000 07 0 1 00000001
5 00000001 ffffffff 0000 08 0 1 00000000
5 80000000 7fffffff 0000 09 0 1 00000001
6 00000007 00000009 0000 0a 0 1 0000003f
6 fffffffd 00000005 0000 0b 0 1 fffffff1
6 fffffffe fffffffe 0000 0c 0 1 00000004
6 80000001 00000003 0000 0d 0 1 80000003
6 00010001 00010001 0000 0e 0 1 00020001
9 00000040 deadbeef 0008 00 0 0 00000000
7 00000040 00000000 0008 10 0 1 deadbeef
a 00000040 000000a5 000a 00 0 0 00000000
8 00000040 00000000 000a 11 0 1 000000a5
7 00000040 00000000 0008 12 0 1 dea5beef
7 00000148 00000000 0000 13 0 1 dea5beef
7 00000050 00000000 fff8 14 0 1 dea5beef
9 00000100 01234567 0004 00 0 0 00000000
7 00000000 00000000 0004 15 0 1 01234567
8 0000004b 00000000 0000 16 0 1 000000de
7 00000040 00000000 0009 17 0 2 00000001
9 00000040 11111111 000a 00 0 2 00000002
7 00000040 00000000 0008 18 0 1 dea5beef
1 00000001 00000001 0000 1f 1 0 00000000
6 00000003 00000004 0000 1e 1 0 00000000
1 00000010 00000020 0000 19 0 1 00000030
a 00000048 12345677 0000 00 0 0 00000000
7 00000048 00000000 0000 1a 0 1 dea5be77
6 00000006 00000007 0000 1b 0 1 0000002a

// ==== tb.f ====
src/exm_pkg.sv
src/mul_counter.sv
src/exm_ctrl.sv
src/exec_unit.sv
src/reg_ex_mem.sv
src/mem_stage.sv
src/exm_top.sv
test/exm_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module exm_tb -f tb.f -o Vexm_tb
	./obj_dir/Vexm_tb | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
